// ==== filelist.f ====
source/backend_pkg.sv
source/tag_cam.sv
source/rename_stage.sv
source/reorder_buffer.sv
source/commit_stage.sv
source/backend_core.sv
verification/tb_clock.sv
verification/backend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing -Wno-fatal --top-module backend_tb -f filelist.f > "$log" 2>&1 \
	&& ./obj_dir/Vbackend_tb >> "$log" 2>&1 \
	|| echo "SOME TESTS FAILED" >> "$log"
cat "$log"
grep -q "SOME TESTS FAILED" "$log" && exit 1 || exit 0

// ==== source/backend_core.sv ====
`timescale 1ns/1ps

module backend_core (
	input  logic                                                  clock,
	input  logic                                                  rst_n,
	input  logic                                                  flush,
	input  logic [backend_pkg::issue_width-1:0]                   disp_valid,
	input  backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0] disp_arch_dst,
	input  logic [backend_pkg::issue_width-1:0]                   disp_halt,
	output logic [backend_pkg::issue_width-1:0]                   disp_ready,
	output backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] disp_tag,
	input  logic [backend_pkg::issue_width-1:0]                   cdb_valid,
	input  backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] cdb_tag,
	output logic [backend_pkg::issue_width-1:0]                   commit_valid,
	output backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0] commit_arch,
	output backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] commit_tag,
	output logic                                                  halted
);

	// Rename to ROB
	logic [backend_pkg::issue_width-1:0]                   alloc_valid;
	backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0] alloc_arch;
	backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] alloc_t_new;
	backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] alloc_t_old;
	logic [backend_pkg::issue_width-1:0]                   alloc_halt;
	logic [$clog2(backend_pkg::rob_depth):0]               free_rows;

	// ROB to commit
	logic [backend_pkg::issue_width-1:0]                   ret_valid;
	backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0] ret_arch;
	backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] ret_t_new;
	backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] ret_t_old;
	logic [backend_pkg::issue_width-1:0]                   ret_halt;

	// Commit feedback
	backend_pkg::free_map_t                                  freed_regs;
	backend_pkg::phys_reg_t [backend_pkg::num_arch_regs-1:0] arch_map_flat;

	rename_stage rename_stage_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.flush         (flush),
		.disp_valid    (disp_valid),
		.disp_arch_dst (disp_arch_dst),
		.disp_halt     (disp_halt),
		.disp_ready    (disp_ready),
		.disp_tag      (disp_tag),
		.free_rows     (free_rows),
		.halted        (halted),
		.freed_regs    (freed_regs),
		.arch_map_flat (arch_map_flat),
		.alloc_valid   (alloc_valid),
		.alloc_arch    (alloc_arch),
		.alloc_t_new   (alloc_t_new),
		.alloc_t_old   (alloc_t_old),
		.alloc_halt    (alloc_halt)
	);

	reorder_buffer reorder_buffer_i (
		.clock       (clock),
		.rst_n       (rst_n),
		.flush       (flush),
		.halted      (halted),
		.alloc_valid (alloc_valid),
		.alloc_arch  (alloc_arch),
		.alloc_t_new (alloc_t_new),
		.alloc_t_old (alloc_t_old),
		.alloc_halt  (alloc_halt),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.free_rows   (free_rows),
		.ret_valid   (ret_valid),
		.ret_arch    (ret_arch),
		.ret_t_new   (ret_t_new),
		.ret_t_old   (ret_t_old),
		.ret_halt    (ret_halt)
	);

	commit_stage commit_stage_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.ret_valid     (ret_valid),
		.ret_arch      (ret_arch),
		.ret_t_new     (ret_t_new),
		.ret_t_old     (ret_t_old),
		.ret_halt      (ret_halt),
		.commit_valid  (commit_valid),
		.commit_arch   (commit_arch),
		.commit_tag    (commit_tag),
		.freed_regs    (freed_regs),
		.arch_map_flat (arch_map_flat),
		.halted        (halted)
	);

endmodule

// ==== source/backend_pkg.sv ====
package backend_pkg;

	// Machine sizes
	localparam int issue_width   = 2;  // Instructions per cycle, dispatch and retire
	localparam int rob_depth     = 8;
	localparam int num_arch_regs = 8;
	localparam int num_phys_regs = 16;

	// Architectural register number
	typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;

	// Physical register tag, also what travels on the CDB
	typedef logic [$clog2(num_phys_regs)-1:0] phys_reg_t;

	// ROB index plus one wrap bit on top
	typedef logic [$clog2(rob_depth):0] rob_ptr_t;

	// One bit per physical register
	typedef logic [num_phys_regs-1:0] free_map_t;

	// Commit stage state
	typedef enum logic {
		running,
		halted
	} commit_state_t;

endpackage

// ==== source/commit_stage.sv ====
`timescale 1ns/1ps

module commit_stage (
	input  logic                                                    clock,
	input  logic                                                    rst_n,
	input  logic [backend_pkg::issue_width-1:0]                     ret_valid,
	input  backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0]   ret_arch,
	input  backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0]   ret_t_new,
	input  backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0]   ret_t_old,
	input  logic [backend_pkg::issue_width-1:0]                     ret_halt,
	output logic [backend_pkg::issue_width-1:0]                     commit_valid,
	output backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0]   commit_arch,
	output backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0]   commit_tag,
	output backend_pkg::free_map_t                                  freed_regs,
	output backend_pkg::phys_reg_t [backend_pkg::num_arch_regs-1:0] arch_map_flat,
	output logic                                                    halted
);

	backend_pkg::commit_state_t state;
	backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] commit_t_old;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			commit_valid <= '0;
			state        <= backend_pkg::running;
			for (int a = 0; a < backend_pkg::num_arch_regs; a++) begin
				arch_map_flat[a] <= backend_pkg::phys_reg_t'(a);
			end
		end else begin
			commit_valid <= ret_valid;
			for (int s = 0; s < backend_pkg::issue_width; s++) begin
				if (ret_valid[s]) begin
					arch_map_flat[ret_arch[s]] <= ret_t_new[s];
					if (ret_halt[s]) begin
						state <= backend_pkg::halted;  // Held until reset
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		commit_arch  <= ret_arch;
		commit_tag   <= ret_t_new;
		commit_t_old <= ret_t_old;
	end

	// Old mappings go back to the pool
	always_comb begin
		freed_regs = '0;
		for (int s = 0; s < backend_pkg::issue_width; s++) begin
			if (commit_valid[s]) begin
				freed_regs[commit_t_old[s]] = 1'b1;
			end
		end
	end

	assign halted = (state == backend_pkg::halted);

endmodule

// ==== source/rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage (
	input  logic                                                    clock,
	input  logic                                                    rst_n,
	input  logic                                                    flush,
	input  logic [backend_pkg::issue_width-1:0]                     disp_valid,
	input  backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0]   disp_arch_dst,
	input  logic [backend_pkg::issue_width-1:0]                     disp_halt,
	output logic [backend_pkg::issue_width-1:0]                     disp_ready,
	output backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0]   disp_tag,
	input  logic [$clog2(backend_pkg::rob_depth):0]                 free_rows,
	input  logic                                                    halted,
	input  backend_pkg::free_map_t                                  freed_regs,
	input  backend_pkg::phys_reg_t [backend_pkg::num_arch_regs-1:0] arch_map_flat,
	output logic [backend_pkg::issue_width-1:0]                     alloc_valid,
	output backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0]   alloc_arch,
	output backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0]   alloc_t_new,
	output backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0]   alloc_t_old,
	output logic [backend_pkg::issue_width-1:0]                     alloc_halt
);

	backend_pkg::phys_reg_t [backend_pkg::num_arch_regs-1:0] map_table;  // Speculative map
	backend_pkg::free_map_t free_map;
	backend_pkg::free_map_t rest_map;    // Pool minus slot 0's pick
	backend_pkg::free_map_t alloc_mask;  // Registers taken this cycle
	backend_pkg::free_map_t arch_used;   // Registers named by the committed map

	// Lowest set bit wins
	function automatic backend_pkg::phys_reg_t lowest_free(input backend_pkg::free_map_t pool);
		lowest_free = '0;
		for (int i = backend_pkg::num_phys_regs-1; i >= 0; i--) begin
			if (pool[i]) begin
				lowest_free = backend_pkg::phys_reg_t'(i);
			end
		end
	endfunction

	assign disp_tag[0] = lowest_free(free_map);
	assign rest_map    = free_map & ~(backend_pkg::free_map_t'(1) << disp_tag[0]);
	assign disp_tag[1] = lowest_free(rest_map);

	// Readiness comes from registered state only
	assign disp_ready[0] = !halted && (free_rows != '0) && (|free_map);
	assign disp_ready[1] = disp_valid[0] && disp_ready[0] && (free_rows >= 2) && (|rest_map);

	assign alloc_valid = disp_valid & disp_ready;
	assign alloc_arch  = disp_arch_dst;
	assign alloc_t_new = disp_tag;
	assign alloc_halt  = disp_halt;

	assign alloc_t_old[0] = map_table[disp_arch_dst[0]];
	// Slot 1 renaming the same register sees slot 0's new tag
	assign alloc_t_old[1] = (alloc_valid[0] && (disp_arch_dst[1] == disp_arch_dst[0])) ?
		disp_tag[0] : map_table[disp_arch_dst[1]];

	always_comb begin
		alloc_mask = '0;
		for (int s = 0; s < backend_pkg::issue_width; s++) begin
			if (alloc_valid[s]) begin
				alloc_mask[disp_tag[s]] = 1'b1;
			end
		end
	end

	always_comb begin
		arch_used = '0;
		for (int a = 0; a < backend_pkg::num_arch_regs; a++) begin
			arch_used[arch_map_flat[a]] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int a = 0; a < backend_pkg::num_arch_regs; a++) begin
				map_table[a] <= backend_pkg::phys_reg_t'(a);  // Identity map
			end
			for (int p = 0; p < backend_pkg::num_phys_regs; p++) begin
				free_map[p] <= (p >= backend_pkg::num_arch_regs);
			end
		end else if (flush) begin
			// Roll back to the committed state
			map_table <= arch_map_flat;
			free_map  <= ~arch_used;
		end else begin
			// Slot 1 goes last so it wins on a shared destination
			for (int s = 0; s < backend_pkg::issue_width; s++) begin
				if (alloc_valid[s]) begin
					map_table[disp_arch_dst[s]] <= disp_tag[s];
				end
			end
			free_map <= (free_map | freed_regs) & ~alloc_mask;
		end
	end

endmodule

// ==== source/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
	input  logic                                                  clock,
	input  logic                                                  rst_n,
	input  logic                                                  flush,
	input  logic                                                  halted,
	input  logic [backend_pkg::issue_width-1:0]                   alloc_valid,
	input  backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0] alloc_arch,
	input  backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] alloc_t_new,
	input  backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] alloc_t_old,
	input  logic [backend_pkg::issue_width-1:0]                   alloc_halt,
	input  logic [backend_pkg::issue_width-1:0]                   cdb_valid,
	input  backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] cdb_tag,
	output logic [$clog2(backend_pkg::rob_depth):0]               free_rows,
	output logic [backend_pkg::issue_width-1:0]                   ret_valid,
	output backend_pkg::arch_reg_t [backend_pkg::issue_width-1:0] ret_arch,
	output backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] ret_t_new,
	output backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] ret_t_old,
	output logic [backend_pkg::issue_width-1:0]                   ret_halt
);

	// Entry table
	logic [backend_pkg::rob_depth-1:0]                     busy;
	logic [backend_pkg::rob_depth-1:0]                     ready;
	logic [backend_pkg::rob_depth-1:0]                     halt;
	backend_pkg::arch_reg_t [backend_pkg::rob_depth-1:0]   ent_arch;
	backend_pkg::phys_reg_t [backend_pkg::rob_depth-1:0]   ent_t_new;
	backend_pkg::phys_reg_t [backend_pkg::rob_depth-1:0]   ent_t_old;

	backend_pkg::rob_ptr_t head;
	backend_pkg::rob_ptr_t tail;

	logic [backend_pkg::rob_depth-1:0] cam_hit;

	// Per-slot table rows, wrap bit dropped
	logic [$clog2(backend_pkg::rob_depth)-1:0] ret_idx   [backend_pkg::issue_width];
	logic [$clog2(backend_pkg::rob_depth)-1:0] alloc_idx [backend_pkg::issue_width];

	logic [$clog2(backend_pkg::rob_depth):0] ret_cnt;
	logic [$clog2(backend_pkg::rob_depth):0] alloc_cnt;

	tag_cam tag_cam_i (
		.entry_tag  (ent_t_new),
		.entry_busy (busy),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.hit        (cam_hit)
	);

	always_comb begin
		for (int s = 0; s < backend_pkg::issue_width; s++) begin
			ret_idx[s]   = $clog2(backend_pkg::rob_depth)'(head + backend_pkg::rob_ptr_t'(s));
			alloc_idx[s] = $clog2(backend_pkg::rob_depth)'(tail + backend_pkg::rob_ptr_t'(s));
		end
	end

	// Oldest entries first; a halt ends the group
	always_comb begin
		for (int s = 0; s < backend_pkg::issue_width; s++) begin
			ret_arch[s]  = ent_arch[ret_idx[s]];
			ret_t_new[s] = ent_t_new[ret_idx[s]];
			ret_t_old[s] = ent_t_old[ret_idx[s]];
			ret_halt[s]  = halt[ret_idx[s]];
			if (s == 0) begin
				ret_valid[s] = !flush && !halted && busy[ret_idx[s]] && ready[ret_idx[s]];
			end else begin
				ret_valid[s] = ret_valid[s-1] && !halt[ret_idx[s-1]] &&
					busy[ret_idx[s]] && ready[ret_idx[s]];
			end
		end
	end

	always_comb begin
		ret_cnt   = '0;
		alloc_cnt = '0;
		for (int s = 0; s < backend_pkg::issue_width; s++) begin
			ret_cnt   = ret_cnt + {{$clog2(backend_pkg::rob_depth){1'b0}}, ret_valid[s]};
			alloc_cnt = alloc_cnt + {{$clog2(backend_pkg::rob_depth){1'b0}}, alloc_valid[s]};
		end
	end

	// Control state
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			busy      <= '0;
			ready     <= '0;
			head      <= '0;
			tail      <= '0;
			free_rows <= backend_pkg::rob_depth[$clog2(backend_pkg::rob_depth):0];
		end else begin
			ready <= ready | cam_hit;  // CDB completion
			for (int s = 0; s < backend_pkg::issue_width; s++) begin
				if (ret_valid[s]) begin
					busy[ret_idx[s]]  <= 1'b0;
					ready[ret_idx[s]] <= 1'b0;
				end
				if (alloc_valid[s]) begin
					busy[alloc_idx[s]]  <= 1'b1;
					ready[alloc_idx[s]] <= 1'b0;
				end
			end
			head      <= head + ret_cnt;
			tail      <= tail + alloc_cnt;
			free_rows <= free_rows + ret_cnt - alloc_cnt;
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		for (int s = 0; s < backend_pkg::issue_width; s++) begin
			if (alloc_valid[s]) begin
				ent_arch[alloc_idx[s]]  <= alloc_arch[s];
				ent_t_new[alloc_idx[s]] <= alloc_t_new[s];
				ent_t_old[alloc_idx[s]] <= alloc_t_old[s];
				halt[alloc_idx[s]]      <= alloc_halt[s];
			end
		end
	end

endmodule

// ==== source/tag_cam.sv ====
`timescale 1ns/1ps

module tag_cam (
	input  backend_pkg::phys_reg_t [backend_pkg::rob_depth-1:0]   entry_tag,
	input  logic [backend_pkg::rob_depth-1:0]                     entry_busy,
	input  logic [backend_pkg::issue_width-1:0]                   cdb_valid,
	input  backend_pkg::phys_reg_t [backend_pkg::issue_width-1:0] cdb_tag,
	output logic [backend_pkg::rob_depth-1:0]                     hit
);

	// Every entry against every CDB slot at once
	always_comb begin
		for (int e = 0; e < backend_pkg::rob_depth; e++) begin
			hit[e] = 1'b0;
			for (int s = 0; s < backend_pkg::issue_width; s++) begin
				if (entry_busy[e] && cdb_valid[s] && (entry_tag[e] == cdb_tag[s])) begin
					hit[e] = 1'b1;
				end
			end
		end
	end

endmodule

// ==== verification/backend_tb.sv ====
`timescale 1ns/1ps

module backend_tb;

	localparam int clock_period    = 40;
	localparam int watchdog_cycles = 400;  // Tests need about 100 cycles
	localparam int commit_limit    = 24;   // Cycles allowed for in-flight work to drain

	typedef struct packed {
		backend_pkg::arch_reg_t arch;
		backend_pkg::phys_reg_t t_new;
		backend_pkg::phys_reg_t t_old;
		logic                   halt;
	} entry_t;

	logic                         clock;
	logic                         rst_n;
	logic                         flush;
	logic [1:0]                   disp_valid;
	backend_pkg::arch_reg_t [1:0] disp_arch_dst;
	logic [1:0]                   disp_halt;
	logic [1:0]                   disp_ready;
	backend_pkg::phys_reg_t [1:0] disp_tag;
	logic [1:0]                   cdb_valid;
	backend_pkg::phys_reg_t [1:0] cdb_tag;
	logic [1:0]                   commit_valid;
	backend_pkg::arch_reg_t [1:0] commit_arch;
	backend_pkg::phys_reg_t [1:0] commit_tag;
	logic                         halted;

	// Reference model
	backend_pkg::phys_reg_t model_map [backend_pkg::num_arch_regs];       // Speculative
	backend_pkg::phys_reg_t model_arch_map [backend_pkg::num_arch_regs];  // Committed
	backend_pkg::free_map_t model_free;
	logic                   model_halted;
	entry_t                 inflight [$];  // Oldest first
	int                     commit_count;
	int                     seed;

	tb_clock #(.period(clock_period), .reset_cycles(3)) tb_clock_i (
		.clock (clock),
		.rst_n (rst_n)
	);

	backend_core backend_core_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.flush         (flush),
		.disp_valid    (disp_valid),
		.disp_arch_dst (disp_arch_dst),
		.disp_halt     (disp_halt),
		.disp_ready    (disp_ready),
		.disp_tag      (disp_tag),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.commit_valid  (commit_valid),
		.commit_arch   (commit_arch),
		.commit_tag    (commit_tag),
		.halted        (halted)
	);

	task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
		if (actual !== expected) begin
			$display("ERR %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic int first_free_reg(input backend_pkg::free_map_t pool);
		for (int i = 0; i < backend_pkg::num_phys_regs; i++) begin
			if (pool[i]) return i;
		end
		return -1;
	endfunction

	// Checks one cycle against the model, then moves to the next falling edge
	task automatic run_cycle();
		backend_pkg::free_map_t pending;
		logic [1:0] exp_ready;
		entry_t e;
		pending = '0;
		#1;
		for (int s = 0; s < 2; s++) begin
			if (model_halted) check(commit_valid[s], 0, "commit after the halt");
			if (commit_valid[s]) begin
				check(inflight.size() > 0, 1, "instruction in flight for a commit");
				e = inflight.pop_front();
				check(commit_arch[s], e.arch, "commit_arch");
				check(commit_tag[s], e.t_new, "commit_tag");
				model_arch_map[e.arch] = e.t_new;
				pending[e.t_old] = 1'b1;  // Back in the pool after this edge
				commit_count++;
				if (e.halt) model_halted = 1'b1;
			end
		end
		check(halted, model_halted, "halted");
		exp_ready[0] = !model_halted && inflight.size() < backend_pkg::rob_depth && model_free != 0;
		exp_ready[1] = disp_valid[0] && exp_ready[0] &&
			inflight.size() + 2 <= backend_pkg::rob_depth && $countones(model_free) >= 2;
		check(disp_ready, exp_ready, "disp_ready");
		if (flush) begin
			inflight.delete();
			model_free = '1;
			for (int a = 0; a < backend_pkg::num_arch_regs; a++) begin
				model_map[a] = model_arch_map[a];
				model_free[model_arch_map[a]] = 1'b0;
			end
		end else begin
			for (int s = 0; s < 2; s++) begin
				if (disp_valid[s] && disp_ready[s]) begin
					check(disp_tag[s], first_free_reg(model_free), "disp_tag");
					e.arch  = disp_arch_dst[s];
					e.t_new = disp_tag[s];
					e.t_old = model_map[disp_arch_dst[s]];
					e.halt  = disp_halt[s];
					model_map[e.arch] = e.t_new;
					model_free[e.t_new] = 1'b0;
					inflight.push_back(e);
				end
			end
			model_free = model_free | pending;
		end
		@(negedge clock);
		flush = 1'b0;
		disp_valid = '0;
		disp_halt = '0;
		cdb_valid = '0;
	endtask

	task automatic dispatch_pair(input logic [1:0] valid, input int a0, input int a1,
		input logic [1:0] halt);
		disp_valid = valid;
		disp_arch_dst[0] = backend_pkg::arch_reg_t'(a0);
		disp_arch_dst[1] = backend_pkg::arch_reg_t'(a1);
		disp_halt = halt;
		run_cycle();
	endtask

	task automatic send_cdb(input logic [1:0] valid, input backend_pkg::phys_reg_t t0,
		input backend_pkg::phys_reg_t t1);
		cdb_valid = valid;
		cdb_tag[0] = t0;
		cdb_tag[1] = t1;
		run_cycle();
	endtask

	task automatic wait_commit_count(input int target);
		for (int i = 0; i < commit_limit && commit_count < target; i++) run_cycle();
		check(commit_count >= target, 1, "commits arrived within the cycle limit");
	endtask

	// Completes everything in flight, two tags per cycle, and waits for the commits
	task automatic complete_all();
		backend_pkg::phys_reg_t tags [$];
		int target;
		target = commit_count + inflight.size();
		foreach (inflight[i]) tags.push_back(inflight[i].t_new);
		while (tags.size() > 1) send_cdb(2'b11, tags.pop_front(), tags.pop_front());
		if (tags.size() == 1) send_cdb(2'b01, tags.pop_front(), '0);
		wait_commit_count(target);
	endtask

	task automatic reset_values();
		disp_valid = 2'b11;
		disp_arch_dst[0] = 3'd1;
		disp_arch_dst[1] = 3'd2;
		#1;
		check(commit_valid, 0, "commit_valid after reset");
		check(halted, 0, "halted after reset");
		check(disp_ready, 2'b11, "disp_ready after reset");
		check(disp_tag[0], 8, "first tag");
		check(disp_tag[1], 9, "second tag");
		run_cycle();
		complete_all();
	endtask

	task automatic in_order_retire();
		int start;
		start = commit_count;
		dispatch_pair(2'b11, 3, 4, 2'b00);
		dispatch_pair(2'b11, 6, 6, 2'b00);  // Same destination in both slots
		send_cdb(2'b11, inflight[3].t_new, inflight[2].t_new);
		send_cdb(2'b11, inflight[1].t_new, inflight[0].t_new);
		run_cycle();
		run_cycle();
		check(commit_count, start + 2, "commits two edges after the last completion");
		wait_commit_count(start + 4);
	endtask

	task automatic pool_reuse();
		backend_pkg::phys_reg_t freed;
		int start;
		for (int i = 0; i < 4; i++) dispatch_pair(2'b11, i, i + 4, 2'b00);
		disp_valid = 2'b01;
		disp_arch_dst[0] = 3'd7;
		#1;
		check(disp_ready[0], 0, "disp_ready with the pool empty");
		run_cycle();
		freed = inflight[0].t_old;
		start = commit_count;
		send_cdb(2'b01, inflight[0].t_new, '0);
		wait_commit_count(start + 1);
		disp_valid = 2'b01;
		disp_arch_dst[0] = 3'd7;
		#1;
		check(disp_tag[0], freed, "tag after the old register returned");
		run_cycle();
		complete_all();
	endtask

	task automatic flush_recovery();
		backend_pkg::phys_reg_t squashed [$];
		int start;
		for (int i = 0; i < 3; i++) dispatch_pair(2'b11, $random(seed), $random(seed), 2'b00);
		start = commit_count;
		send_cdb(2'b01, inflight[0].t_new, '0);
		wait_commit_count(start + 1);
		foreach (inflight[i]) squashed.push_back(inflight[i].t_new);
		send_cdb(2'b11, squashed[1], squashed[2]);  // Ready but blocked behind the head
		flush = 1'b1;
		run_cycle();
		send_cdb(2'b11, squashed[0], squashed[3]);  // Stale tags hit nothing
		run_cycle();
		run_cycle();
		check(commit_count, start + 1, "commits after the flush");
		dispatch_pair(2'b11, $random(seed), $random(seed), 2'b00);
		complete_all();
	endtask

	task automatic halt_blocks_retire();
		dispatch_pair(2'b11, 3, 4, 2'b01);  // Slot 0 halts
		dispatch_pair(2'b11, 5, 6, 2'b00);
		send_cdb(2'b11, inflight[2].t_new, inflight[3].t_new);
		send_cdb(2'b11, inflight[0].t_new, inflight[1].t_new);
		for (int i = 0; i < commit_limit && !model_halted; i++) run_cycle();
		check(model_halted, 1, "halt committed within the cycle limit");
		for (int i = 0; i < 4; i++) begin
			disp_valid = 2'b11;
			#1;
			check(disp_ready, 2'b00, "disp_ready while halted");
			run_cycle();
		end
	endtask

	initial begin
		#(watchdog_cycles * clock_period);
		$display("Watchdog expired after %0d clock periods, the tests did not finish",
			watchdog_cycles);
		$display("SOME TESTS FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		seed = 61;
		commit_count = 0;
		flush = 1'b0;
		disp_valid = '0;
		disp_arch_dst = '0;
		disp_halt = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		model_halted = 1'b0;
		model_free = 16'hff00;  // Registers 8 to 15
		for (int a = 0; a < backend_pkg::num_arch_regs; a++) begin
			model_map[a] = backend_pkg::phys_reg_t'(a);
			model_arch_map[a] = backend_pkg::phys_reg_t'(a);
		end
		wait (rst_n);
		reset_values();
		in_order_retire();
		pool_reuse();
		flush_recovery();
		halt_blocks_retire();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int period       = 40,
	parameter int reset_cycles = 3
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// Released on a falling edge, like every other input
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule
